//--- filelist.f
+incdir+include
verilog/exec_types_pkg.sv
verilog/warp_ctl_pkg.sv
verilog/exec_if.sv
verilog/alu_unit.sv
verilog/sfu_unit.sv
verilog/redirect_ctl.sv
verilog/execute_scalar.sv
testbench/tb_execute_scalar.sv

//--- Makefile
# Verilator build and run of the scalar execute stage testbench
VERILATOR  ?= verilator
TOP        := tb_execute_scalar
FILELIST   := filelist.f
BUILD_DIR  := obj_dir
VFLAGS     := --binary --timing -j 0 --top-module $(TOP) -Mdir $(BUILD_DIR)
LINT_FLAGS := --lint-only --timing -Wall --top-module $(TOP)
PASS_MSG   := TEST RESULT: PASS
SOURCES    := $(wildcard verilog/*.sv testbench/*.sv include/*.svh)

.PHONY: all run lint clean

all: run

$(BUILD_DIR)/V$(TOP): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST)

run: $(BUILD_DIR)/V$(TOP)
	@out="$$($(BUILD_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)

//--- include/exec_model.svh
// include inside a module that imports exec_types_pkg and warp_ctl_pkg; one expected queue per unit
`ifndef EXEC_MODEL_SVH
`define EXEC_MODEL_SVH

// expected commit, with the branch or warp-control side data
typedef struct {
    int                 wid;
    logic [RD_BITS-1:0] rd;
    logic [XLEN-1:0]    data;
    logic [XLEN-1:0]    pc;
    logic               ctl;
    logic               taken;
    logic [XLEN-1:0]    dest;
    logic [OP_BITS-1:0] op;
    logic [XLEN-1:0]    rs1;
    logic [XLEN-1:0]    rs2;
} exp_commit_t;

exp_commit_t   alu_q[$];
exp_commit_t   sfu_q[$];
wspawn_state_e model_ws = IDLE;

function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
endfunction

task automatic model_push(input bit is_sfu, input int wid, input logic [OP_BITS-1:0] op,
                          input logic [XLEN-1:0] pc, input logic [XLEN-1:0] rs1,
                          input logic [XLEN-1:0] rs2, input logic [XLEN-1:0] imm,
                          input logic [RD_BITS-1:0] rd);
    exp_commit_t e;
    e = '{wid: wid, rd: rd, data: '0, pc: pc, ctl: 1'b0, taken: 1'b0,
          dest: pc + imm, op: op, rs1: rs1, rs2: rs2};
    if (is_sfu) begin
        e.ctl  = (op == WSPAWN || op == TMC);
        e.data = (op == WID) ? XLEN'(wid) : '0;
        sfu_q.push_back(e);
    end else begin
        case (alu_op_e'(op))
            ADD: e.data = rs1 + rs2;
            SUB: e.data = rs1 - rs2;
            AND: e.data = rs1 & rs2;
            OR:  e.data = rs1 | rs2;
            XOR: e.data = rs1 ^ rs2;
            SLT: e.data = XLEN'($signed(rs1) < $signed(rs2));
            BEQ: e.taken = (rs1 == rs2);
            BNE: e.taken = (rs1 != rs2);
            JAL, JALR: begin
                e.taken = 1'b1;
                e.data  = pc + 4;
            end
            default: e.data = '0;
        endcase
        e.ctl = (op >= BEQ && op <= JALR);
        if (alu_op_e'(op) == JALR) e.dest = (rs1 + imm) & ~XLEN'(1);
        alu_q.push_back(e);
    end
endtask

// one clock step of the capture sequence
task automatic model_ws_step(input logic trigger, input logic sfu_fire, output logic spawn);
    spawn = (model_ws == ARMED) && sfu_fire;
    if (trigger) model_ws = WAIT1;
    else if (model_ws == WAIT1) model_ws = WAIT2;
    else if (model_ws == WAIT2) model_ws = ARMED;
    else if (spawn) model_ws = IDLE;
endtask

`endif

//--- testbench/tb_execute_scalar.sv
// runs with WARP_CNT and THREAD_CNT of 4; 300 random ops per unit from a fixed LCG seed
`timescale 1ns/10ps

module tb_execute_scalar import exec_types_pkg::*; import warp_ctl_pkg::*; ();
    localparam int WARP_CNT   = 4;
    localparam int THREAD_CNT = 4;
    localparam int WID_W      = 2;
    localparam int N_OPS      = 300;
    // 20 cycles per issued op plus reset
    localparam int TIMEOUT_NS = (2 * N_OPS * 20 + 8) * 10;

    logic                  clk;
    logic                  reset;
    logic                  alu_valid, alu_ready, alu_commit_valid, alu_commit_ready;
    logic                  sfu_valid, sfu_ready, sfu_commit_valid, sfu_commit_ready;
    logic [WID_W-1:0]      alu_wid, sfu_wid, alu_commit_wid, sfu_commit_wid, branch_wid;
    logic [OP_BITS-1:0]    alu_op, sfu_op, wctl_op;
    logic [XLEN-1:0]       alu_pc, alu_rs1, alu_rs2, alu_imm;
    logic [XLEN-1:0]       sfu_pc, sfu_rs1, sfu_rs2, sfu_imm;
    logic [RD_BITS-1:0]    alu_rd, sfu_rd, alu_commit_rd, sfu_commit_rd;
    logic [XLEN-1:0]       alu_commit_data, alu_commit_pc, sfu_commit_data, sfu_commit_pc;
    logic [XLEN-1:0]       ipc, branch_dest, wctl_pc, ras, spawn_pc;
    logic                  branch_valid, branch_taken, wctl_valid;
    logic [WARP_CNT-1:0]   wctl_wmask;
    logic [THREAD_CNT-1:0] wctl_tmask;
    logic                  ras_write, spawn_write, flush, sim_ebreak;

    logic [31:0] seed = 32'd60126;
    int          mismatches = 0;
    int          failures = 0;
    int          alu_issued = 0;
    int          sfu_issued = 0;
    bit          alu_took;
    bit          sfu_took;

    `include "exec_model.svh"

    execute_scalar #(.WARP_CNT(WARP_CNT), .THREAD_CNT(THREAD_CNT)) i_dut (.*);

    function automatic logic [31:0] rnd32();
        seed = lcg_next(seed);
        return seed;
    endfunction

    // take the upper bits of the LCG state
    function automatic int pick(input int n);
        return int'(rnd32() >> 16) % n;
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] exp_val,
                                   input logic [31:0] act_val);
        mismatches++;
        $display("MISMATCH %s: expected %h, actual %h at %0t", name, exp_val, act_val, $time);
    endtask

    task automatic report_error(input string msg);
        failures++;
        $display("ERROR %s at %0t", msg, $time);
    endtask

    // mid-cycle compare of every output against the model
    task automatic check_cycle();
        exp_commit_t ea;
        exp_commit_t es;
        logic        exp_alu_ready;
        logic        exp_sfu_ready;
        logic        exp_br;
        logic        exp_taken;
        logic        zero_jump;
        logic        exp_wctl;
        logic        exp_flush;
        logic        trigger;
        logic        sfu_done;
        logic        exp_spawn;
        logic        exp_stop;
        exp_br    = 1'b0;
        exp_taken = 1'b0;
        zero_jump = 1'b0;
        exp_wctl  = 1'b0;
        exp_flush = 1'b0;
        trigger   = 1'b0;
        sfu_done  = sfu_commit_valid && sfu_commit_ready;
        if (alu_commit_valid && alu_q.size() == 0)
            report_error("alu commit valid without a pending dispatch");
        if (sfu_commit_valid && sfu_q.size() == 0)
            report_error("sfu commit valid without a pending dispatch");
        // a unit takes a dispatch when it holds nothing or its result leaves
        exp_alu_ready = (alu_q.size() == 0) || alu_commit_ready;
        exp_sfu_ready = (sfu_q.size() == 0) || sfu_commit_ready;
        if (alu_ready !== exp_alu_ready)
            report_mismatch("alu ready", 32'(exp_alu_ready), 32'(alu_ready));
        if (sfu_ready !== exp_sfu_ready)
            report_mismatch("sfu ready", 32'(exp_sfu_ready), 32'(sfu_ready));
        if (alu_commit_valid && alu_commit_ready && alu_q.size() > 0) begin
            ea = alu_q.pop_front();
            if (alu_commit_wid !== WID_W'(ea.wid))
                report_mismatch("alu wid", 32'(ea.wid), 32'(alu_commit_wid));
            if (alu_commit_rd !== ea.rd)
                report_mismatch("alu rd", 32'(ea.rd), 32'(alu_commit_rd));
            if (alu_commit_data !== ea.data)
                report_mismatch("alu data", ea.data, alu_commit_data);
            if (alu_commit_pc !== ea.pc)
                report_mismatch("alu pc", ea.pc, alu_commit_pc);
            exp_br    = ea.ctl;
            exp_taken = ea.ctl && ea.taken;
            zero_jump = exp_taken && ea.dest == '0;
            if (exp_br && branch_taken !== ea.taken)
                report_mismatch("branch taken", 32'(ea.taken), 32'(branch_taken));
            if (exp_br && branch_wid !== WID_W'(ea.wid))
                report_mismatch("branch wid", 32'(ea.wid), 32'(branch_wid));
            if (exp_br && branch_dest !== (zero_jump ? ipc : ea.dest))
                report_mismatch("branch dest", zero_jump ? ipc : ea.dest, branch_dest);
            if (zero_jump && ras !== ea.pc + 32'd4)
                report_mismatch("ras", ea.pc + 32'd4, ras);
        end
        if (branch_valid !== exp_br)
            report_mismatch("branch valid", 32'(exp_br), 32'(branch_valid));
        if (ras_write !== zero_jump)
            report_mismatch("ras write", 32'(zero_jump), 32'(ras_write));
        if (sfu_done && sfu_q.size() > 0) begin
            es = sfu_q.pop_front();
            if (sfu_commit_wid !== WID_W'(es.wid))
                report_mismatch("sfu wid", 32'(es.wid), 32'(sfu_commit_wid));
            if (sfu_commit_rd !== es.rd)
                report_mismatch("sfu rd", 32'(es.rd), 32'(sfu_commit_rd));
            if (sfu_commit_data !== es.data)
                report_mismatch("sfu data", es.data, sfu_commit_data);
            if (sfu_commit_pc !== es.pc)
                report_mismatch("sfu pc", es.pc, sfu_commit_pc);
            exp_wctl = es.ctl;
            if (exp_wctl && wctl_op !== es.op)
                report_mismatch("wctl op", 32'(es.op), 32'(wctl_op));
            if (exp_wctl && wctl_wmask !== es.rs1[WARP_CNT-1:0])
                report_mismatch("wctl wmask", 32'(es.rs1[WARP_CNT-1:0]), 32'(wctl_wmask));
            if (exp_wctl && wctl_pc !== es.rs2)
                report_mismatch("wctl pc", es.rs2, wctl_pc);
            if (exp_wctl && wctl_tmask !== es.rs1[THREAD_CNT-1:0])
                report_mismatch("wctl tmask", 32'(es.rs1[THREAD_CNT-1:0]), 32'(wctl_tmask));
            exp_flush = es.op == TMC && es.rs1[THREAD_CNT-1:0] == '0;
            trigger   = es.op == WSPAWN && es.rs2 == '0 && es.rs1[WARP_CNT-1:0] == '0;
        end
        if (wctl_valid !== exp_wctl)
            report_mismatch("wctl valid", 32'(exp_wctl), 32'(wctl_valid));
        exp_flush = exp_flush || exp_taken;
        if (flush !== exp_flush)
            report_mismatch("flush", 32'(exp_flush), 32'(flush));
        model_ws_step(trigger, sfu_done, exp_spawn);
        if (spawn_write !== exp_spawn)
            report_mismatch("spawn write", 32'(exp_spawn), 32'(spawn_write));
        if (exp_spawn && spawn_pc !== es.pc + 32'd4)
            report_mismatch("spawn pc", es.pc + 32'd4, spawn_pc);
        alu_took = alu_valid && alu_ready;
        sfu_took = sfu_valid && sfu_ready;
        exp_stop = alu_took && alu_wid == WID_W'(0) && (alu_op == EBREAK || alu_op == ECALL);
        if (sim_ebreak !== exp_stop)
            report_mismatch("sim ebreak", 32'(exp_stop), 32'(sim_ebreak));
        if (alu_took) begin
            model_push(1'b0, int'(alu_wid), alu_op, alu_pc, alu_rs1, alu_rs2, alu_imm, alu_rd);
            alu_issued++;
        end
        if (sfu_took) begin
            model_push(1'b1, int'(sfu_wid), sfu_op, sfu_pc, sfu_rs1, sfu_rs2, sfu_imm, sfu_rd);
            sfu_issued++;
        end
    endtask

    task automatic drive_alu();
        int                 kind;
        logic [OP_BITS-1:0] op;
        logic [XLEN-1:0]    pc;
        logic [XLEN-1:0]    rs1;
        logic [XLEN-1:0]    imm;
        kind = pick(8);
        op   = OP_BITS'(pick(12));
        pc   = rnd32() & ~32'h3;
        rs1  = rnd32();
        imm  = (pick(2) == 0) ? XLEN'(pick(4096)) : rnd32();
        // directed jumps whose target lands on zero
        if (kind == 0) begin
            op  = JAL;
            imm = XLEN'(0) - pc;
        end else if (kind == 1) begin
            op  = JALR;
            rs1 = XLEN'(pick(2)) - imm;
        end
        alu_valid <= 1'b1;
        alu_wid   <= WID_W'(pick(WARP_CNT));
        alu_op    <= op;
        alu_pc    <= pc;
        alu_rs1   <= rs1;
        alu_rs2   <= (pick(2) == 0) ? rs1 : rnd32();
        alu_imm   <= imm;
        alu_rd    <= RD_BITS'(pick(32));
    endtask

    task automatic drive_sfu();
        int                 kind;
        logic [OP_BITS-1:0] op;
        logic [XLEN-1:0]    rs1;
        logic [XLEN-1:0]    rs2;
        kind = pick(6);
        op   = OP_BITS'(pick(3));
        rs1  = rnd32();
        rs2  = rnd32();
        // wspawn at pc 0 with an empty or a random warp mask
        if (kind == 0) begin
            op  = WSPAWN;
            rs1 = (pick(2) == 0) ? (rnd32() << WARP_CNT) : rnd32();
            rs2 = '0;
        end else if (kind == 1) begin
            op  = TMC;
            rs1 = rnd32() << THREAD_CNT;
        end
        sfu_valid <= 1'b1;
        sfu_wid   <= WID_W'(pick(WARP_CNT));
        sfu_op    <= op;
        sfu_pc    <= rnd32() & ~32'h3;
        sfu_rs1   <= rs1;
        sfu_rs2   <= rs2;
        sfu_imm   <= rnd32();
        sfu_rd    <= RD_BITS'(pick(32));
    endtask

    task automatic drive_inputs();
        if (!alu_valid || alu_took) begin
            if (alu_issued < N_OPS && pick(4) != 0)
                drive_alu();
            else
                alu_valid <= 1'b0;
        end
        if (!sfu_valid || sfu_took) begin
            if (sfu_issued < N_OPS && pick(4) != 0)
                drive_sfu();
            else
                sfu_valid <= 1'b0;
        end
        // commit back-pressure about a third of the time
        alu_commit_ready <= (pick(3) != 0);
        sfu_commit_ready <= (pick(3) != 0);
    endtask

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        reset            = 1'b1;
        ipc              = 32'h0000_0800;
        alu_valid        = 1'b0;
        alu_wid          = '0;
        alu_op           = '0;
        alu_pc           = '0;
        alu_rs1          = '0;
        alu_rs2          = '0;
        alu_imm          = '0;
        alu_rd           = '0;
        alu_commit_ready = 1'b1;
        sfu_valid        = 1'b0;
        sfu_wid          = '0;
        sfu_op           = '0;
        sfu_pc           = '0;
        sfu_rs1          = '0;
        sfu_rs2          = '0;
        sfu_imm          = '0;
        sfu_rd           = '0;
        sfu_commit_ready = 1'b1;
        repeat (8) @(posedge clk);
        reset <= 1'b0;
        while (alu_issued < N_OPS || sfu_issued < N_OPS
               || alu_q.size() > 0 || sfu_q.size() > 0) begin
            @(negedge clk);
            check_cycle();
            @(posedge clk);
            drive_inputs();
        end
        $display("errors: %0d mismatches, %0d other failures, %0d alu and %0d sfu ops",
                 mismatches, failures, alu_issued, sfu_issued);
        if (mismatches == 0 && failures == 0)
            $display("TEST RESULT: PASS");
        else
            $display("TEST RESULT: FAIL");
        $finish;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("watchdog: run hung, %0d alu and %0d sfu ops issued, %0d mismatches",
                 alu_issued, sfu_issued, mismatches);
        $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

//--- verilog/execute_scalar.sv
// single-issue scalar execute stage; no registers here, every latency is the unit latency
`timescale 1ns/10ps

module execute_scalar import exec_types_pkg::*; #(
    parameter int  WARP_CNT   = 4,
    parameter int  THREAD_CNT = 4,
    localparam int WID_W      = (WARP_CNT > 1) ? $clog2(WARP_CNT) : 1
) (
    input  logic                  clk,
    input  logic                  reset,
    // alu dispatch
    input  logic                  alu_valid,
    output logic                  alu_ready,
    input  logic [WID_W-1:0]      alu_wid,
    input  logic [OP_BITS-1:0]    alu_op,
    input  logic [XLEN-1:0]       alu_pc,
    input  logic [XLEN-1:0]       alu_rs1,
    input  logic [XLEN-1:0]       alu_rs2,
    input  logic [XLEN-1:0]       alu_imm,
    input  logic [RD_BITS-1:0]    alu_rd,
    // alu commit
    output logic                  alu_commit_valid,
    input  logic                  alu_commit_ready,
    output logic [WID_W-1:0]      alu_commit_wid,
    output logic [RD_BITS-1:0]    alu_commit_rd,
    output logic [XLEN-1:0]       alu_commit_data,
    output logic [XLEN-1:0]       alu_commit_pc,
    // sfu dispatch
    input  logic                  sfu_valid,
    output logic                  sfu_ready,
    input  logic [WID_W-1:0]      sfu_wid,
    input  logic [OP_BITS-1:0]    sfu_op,
    input  logic [XLEN-1:0]       sfu_pc,
    input  logic [XLEN-1:0]       sfu_rs1,
    input  logic [XLEN-1:0]       sfu_rs2,
    input  logic [XLEN-1:0]       sfu_imm,
    input  logic [RD_BITS-1:0]    sfu_rd,
    // sfu commit
    output logic                  sfu_commit_valid,
    input  logic                  sfu_commit_ready,
    output logic [WID_W-1:0]      sfu_commit_wid,
    output logic [RD_BITS-1:0]    sfu_commit_rd,
    output logic [XLEN-1:0]       sfu_commit_data,
    output logic [XLEN-1:0]       sfu_commit_pc,
    input  logic [XLEN-1:0]       ipc,
    output logic                  branch_valid,
    output logic                  branch_taken,
    output logic [WID_W-1:0]      branch_wid,
    output logic [XLEN-1:0]       branch_dest,
    output logic                  wctl_valid,
    output logic [OP_BITS-1:0]    wctl_op,
    output logic [WARP_CNT-1:0]   wctl_wmask,
    output logic [XLEN-1:0]       wctl_pc,
    output logic [THREAD_CNT-1:0] wctl_tmask,
    output logic [XLEN-1:0]       ras,
    output logic                  ras_write,
    output logic [XLEN-1:0]       spawn_pc,
    output logic                  spawn_write,
    output logic                  flush,
    output logic                  sim_ebreak
);
    dispatch_if #(.WARP_CNT(WARP_CNT)) alu_disp ();
    dispatch_if #(.WARP_CNT(WARP_CNT)) sfu_disp ();
    commit_if   #(.WARP_CNT(WARP_CNT)) alu_cmt ();
    commit_if   #(.WARP_CNT(WARP_CNT)) sfu_cmt ();
    branch_if   #(.WARP_CNT(WARP_CNT)) raw_br ();
    branch_if   #(.WARP_CNT(WARP_CNT)) br_out ();
    warp_ctl_if #(.WARP_CNT(WARP_CNT), .THREAD_CNT(THREAD_CNT)) wctl ();

    assign alu_disp.valid = alu_valid;
    assign alu_disp.wid   = alu_wid;
    assign alu_disp.op    = alu_op;
    assign alu_disp.pc    = alu_pc;
    assign alu_disp.rs1   = alu_rs1;
    assign alu_disp.rs2   = alu_rs2;
    assign alu_disp.imm   = alu_imm;
    assign alu_disp.rd    = alu_rd;
    assign alu_ready      = alu_disp.ready;

    assign sfu_disp.valid = sfu_valid;
    assign sfu_disp.wid   = sfu_wid;
    assign sfu_disp.op    = sfu_op;
    assign sfu_disp.pc    = sfu_pc;
    assign sfu_disp.rs1   = sfu_rs1;
    assign sfu_disp.rs2   = sfu_rs2;
    assign sfu_disp.imm   = sfu_imm;
    assign sfu_disp.rd    = sfu_rd;
    assign sfu_ready      = sfu_disp.ready;

    assign alu_cmt.ready    = alu_commit_ready;
    assign alu_commit_valid = alu_cmt.valid;
    assign alu_commit_wid   = alu_cmt.wid;
    assign alu_commit_rd    = alu_cmt.rd;
    assign alu_commit_data  = alu_cmt.data;
    assign alu_commit_pc    = alu_cmt.pc;

    assign sfu_cmt.ready    = sfu_commit_ready;
    assign sfu_commit_valid = sfu_cmt.valid;
    assign sfu_commit_wid   = sfu_cmt.wid;
    assign sfu_commit_rd    = sfu_cmt.rd;
    assign sfu_commit_data  = sfu_cmt.data;
    assign sfu_commit_pc    = sfu_cmt.pc;

    assign branch_valid = br_out.valid;
    assign branch_taken = br_out.taken;
    assign branch_wid   = br_out.wid;
    assign branch_dest  = br_out.dest;

    assign wctl_valid = wctl.valid;
    assign wctl_op    = wctl.op;
    assign wctl_wmask = wctl.wmask;
    assign wctl_pc    = wctl.pc;
    assign wctl_tmask = wctl.tmask;

    alu_unit #(.WARP_CNT(WARP_CNT)) i_alu (
        .clk      (clk),
        .reset    (reset),
        .dispatch (alu_disp),
        .commit   (alu_cmt),
        .branch   (raw_br)
    );

    sfu_unit #(.WARP_CNT(WARP_CNT), .THREAD_CNT(THREAD_CNT)) i_sfu (
        .clk      (clk),
        .reset    (reset),
        .dispatch (sfu_disp),
        .commit   (sfu_cmt),
        .warp_ctl (wctl)
    );

    // alu dispatch bundle is observed only, for the stop pulse
    redirect_ctl #(.WARP_CNT(WARP_CNT)) i_redirect (
        .clk          (clk),
        .reset        (reset),
        .ipc          (ipc),
        .alu_dispatch (alu_disp),
        .alu_commit   (alu_cmt),
        .sfu_commit   (sfu_cmt),
        .raw_branch   (raw_br),
        .warp_ctl     (wctl),
        .branch_out   (br_out),
        .ras          (ras),
        .ras_write    (ras_write),
        .spawn_pc     (spawn_pc),
        .spawn_write  (spawn_write),
        .flush        (flush),
        .sim_ebreak   (sim_ebreak)
    );

endmodule

//--- verilog/redirect_ctl.sv
// interrupt overloads on branch and wspawn; all outputs combinational except the capture state
`timescale 1ns/10ps

module redirect_ctl import exec_types_pkg::*; import warp_ctl_pkg::*; #(
    parameter int WARP_CNT = 4
) (
    input  logic            clk,
    input  logic            reset,
    input  logic [XLEN-1:0] ipc,
    dispatch_if.sink        alu_dispatch,
    commit_if.monitor       alu_commit,
    commit_if.monitor       sfu_commit,
    branch_if.sink          raw_branch,
    warp_ctl_if.sink        warp_ctl,
    branch_if.src           branch_out,
    output logic [XLEN-1:0] ras,
    output logic            ras_write,
    output logic [XLEN-1:0] spawn_pc,
    output logic            spawn_write,
    output logic            flush,
    output logic            sim_ebreak
);
    localparam int WID_W = (WARP_CNT > 1) ? $clog2(WARP_CNT) : 1;

    logic          jump_to_zero;
    logic          trigger;
    logic          sfu_fire;
    alu_op_e       disp_op;
    wspawn_state_e ws_state;
    wspawn_state_e ws_next;

    // taken jump to 0 goes to the interrupt pc and saves the return address
    assign jump_to_zero = raw_branch.valid && raw_branch.taken && (raw_branch.dest == '0);

    assign branch_out.valid = raw_branch.valid;
    assign branch_out.taken = raw_branch.taken;
    assign branch_out.wid   = raw_branch.wid;
    assign branch_out.dest  = jump_to_zero ? ipc : raw_branch.dest;

    assign ras       = alu_commit.pc + XLEN'(4);
    assign ras_write = jump_to_zero;

    assign flush = (branch_out.valid && branch_out.taken)
                 || (warp_ctl.valid && warp_ctl.op == TMC && warp_ctl.tmask == '0);

    // wspawn capture
    assign trigger  = warp_ctl.valid && warp_ctl.op == WSPAWN
                   && warp_ctl.pc == '0 && warp_ctl.wmask == '0;
    assign sfu_fire = sfu_commit.valid && sfu_commit.ready;

    always_comb begin
        ws_next = ws_state;
        if (trigger) begin
            ws_next = WAIT1;
        end else begin
            case (ws_state)
                IDLE:  ws_next = IDLE;
                WAIT1: ws_next = WAIT2;
                WAIT2: ws_next = ARMED;
                ARMED: ws_next = sfu_fire ? IDLE : ARMED;
                default: ws_next = IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            ws_state <= IDLE;
        end else begin
            ws_state <= ws_next;
        end
    end

    assign spawn_pc    = sfu_commit.pc + XLEN'(4);
    assign spawn_write = (ws_state == ARMED) && sfu_fire;

    // stop request for warp 0 only
    assign disp_op    = alu_op_e'(alu_dispatch.op);
    assign sim_ebreak = alu_dispatch.valid && alu_dispatch.ready
                     && alu_dispatch.wid == WID_W'(0)
                     && (disp_op == EBREAK || disp_op == ECALL);

endmodule

//--- verilog/sfu_unit.sv
// one-entry SFU; THREAD_CNT and WARP_CNT must not exceed XLEN since masks come from rs1
`timescale 1ns/10ps

module sfu_unit import exec_types_pkg::*; import warp_ctl_pkg::*; #(
    parameter int WARP_CNT   = 4,
    parameter int THREAD_CNT = 4
) (
    input  logic     clk,
    input  logic     reset,
    dispatch_if.sink dispatch,
    commit_if.src    commit,
    warp_ctl_if.src  warp_ctl
);
    localparam int WID_W = (WARP_CNT > 1) ? $clog2(WARP_CNT) : 1;

    logic                fire_in;
    logic                fire_out;
    logic                out_valid;
    sfu_op_e             out_op;
    logic [WID_W-1:0]    out_wid;
    logic [RD_BITS-1:0]  out_rd;
    logic [XLEN-1:0]     out_pc;
    logic [XLEN-1:0]     out_rs1;
    logic [XLEN-1:0]     out_rs2;

    assign fire_in  = dispatch.valid && dispatch.ready;
    assign fire_out = out_valid && commit.ready;
    assign dispatch.ready = !out_valid || commit.ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid <= 1'b0;
        end else if (fire_in) begin
            out_valid <= 1'b1;
        end else if (fire_out) begin
            out_valid <= 1'b0;
        end
    end

    // operands kept raw, decoded on the way out
    always_ff @(posedge clk) begin
        if (fire_in) begin
            out_op  <= sfu_op_e'(dispatch.op);
            out_wid <= dispatch.wid;
            out_rd  <= dispatch.rd;
            out_pc  <= dispatch.pc;
            out_rs1 <= dispatch.rs1;
            out_rs2 <= dispatch.rs2;
        end
    end

    assign commit.valid = out_valid;
    assign commit.wid   = out_wid;
    assign commit.rd    = out_rd;
    assign commit.pc    = out_pc;
    // only WID returns data
    assign commit.data  = (out_op == WID) ? XLEN'(out_wid) : '0;

    assign warp_ctl.valid = fire_out && (out_op == WSPAWN || out_op == TMC);
    assign warp_ctl.op    = out_op;
    assign warp_ctl.wmask = out_rs1[WARP_CNT-1:0];
    assign warp_ctl.pc    = out_rs2;
    assign warp_ctl.tmask = out_rs1[THREAD_CNT-1:0];

endmodule

//--- verilog/alu_unit.sv
// one-entry ALU; result and branch outcome are held until the commit transfer
`timescale 1ns/10ps

module alu_unit import exec_types_pkg::*; #(
    parameter int WARP_CNT = 4
) (
    input  logic     clk,
    input  logic     reset,
    dispatch_if.sink dispatch,
    commit_if.src    commit,
    branch_if.src    branch
);
    localparam int WID_W = (WARP_CNT > 1) ? $clog2(WARP_CNT) : 1;

    alu_op_e             op;
    logic                fire_in;
    logic                fire_out;
    logic [XLEN-1:0]     result;
    logic [XLEN-1:0]     target;
    logic                is_br;
    logic                taken;

    // output register
    logic                out_valid;
    logic [WID_W-1:0]    out_wid;
    logic [RD_BITS-1:0]  out_rd;
    logic [XLEN-1:0]     out_data;
    logic [XLEN-1:0]     out_pc;
    logic [XLEN-1:0]     out_dest;
    logic                out_is_br;
    logic                out_taken;

    assign op       = alu_op_e'(dispatch.op);
    assign fire_in  = dispatch.valid && dispatch.ready;
    assign fire_out = out_valid && commit.ready;

    // accept when empty or when the held result leaves this cycle
    assign dispatch.ready = !out_valid || commit.ready;

    always_comb begin
        result = '0;
        is_br  = 1'b0;
        taken  = 1'b0;
        target = dispatch.pc + dispatch.imm;
        case (op)
            ADD: result = dispatch.rs1 + dispatch.rs2;
            SUB: result = dispatch.rs1 - dispatch.rs2;
            AND: result = dispatch.rs1 & dispatch.rs2;
            OR:  result = dispatch.rs1 | dispatch.rs2;
            XOR: result = dispatch.rs1 ^ dispatch.rs2;
            SLT: result = XLEN'($signed(dispatch.rs1) < $signed(dispatch.rs2));
            BEQ: begin
                is_br = 1'b1;
                taken = (dispatch.rs1 == dispatch.rs2);
            end
            BNE: begin
                is_br = 1'b1;
                taken = (dispatch.rs1 != dispatch.rs2);
            end
            JAL: begin
                is_br  = 1'b1;
                taken  = 1'b1;
                result = dispatch.pc + XLEN'(4);
            end
            JALR: begin
                is_br  = 1'b1;
                taken  = 1'b1;
                result = dispatch.pc + XLEN'(4);
                target = (dispatch.rs1 + dispatch.imm) & ~XLEN'(1);
            end
            // ebreak and ecall write zero
            default: result = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid <= 1'b0;
        end else if (fire_in) begin
            out_valid <= 1'b1;
        end else if (fire_out) begin
            out_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (fire_in) begin
            out_wid   <= dispatch.wid;
            out_rd    <= dispatch.rd;
            out_data  <= result;
            out_pc    <= dispatch.pc;
            out_dest  <= target;
            out_is_br <= is_br;
            out_taken <= taken;
        end
    end

    assign commit.valid = out_valid;
    assign commit.wid   = out_wid;
    assign commit.rd    = out_rd;
    assign commit.data  = out_data;
    assign commit.pc    = out_pc;

    // branch outcome leaves with the commit transfer
    assign branch.valid = fire_out && out_is_br;
    assign branch.taken = out_taken;
    assign branch.wid   = out_wid;
    assign branch.dest  = out_dest;

endmodule

//--- verilog/exec_if.sv
// execute-stage bundles; wid is clog2(WARP_CNT) bits wide with a minimum of one bit
`timescale 1ns/10ps

interface dispatch_if import exec_types_pkg::*; #(
    parameter int WARP_CNT = 4
) ();
    localparam int WID_W = (WARP_CNT > 1) ? $clog2(WARP_CNT) : 1;

    logic                valid;
    logic                ready;
    logic [WID_W-1:0]    wid;
    logic [OP_BITS-1:0]  op;
    logic [XLEN-1:0]     pc;
    logic [XLEN-1:0]     rs1;
    logic [XLEN-1:0]     rs2;
    logic [XLEN-1:0]     imm;
    logic [RD_BITS-1:0]  rd;

    // source holds every field while valid is high and ready is low
    modport src (output valid, wid, op, pc, rs1, rs2, imm, rd, input ready);
    modport sink (input valid, wid, op, pc, rs1, rs2, imm, rd, output ready);
endinterface

interface commit_if import exec_types_pkg::*; #(
    parameter int WARP_CNT = 4
) ();
    localparam int WID_W = (WARP_CNT > 1) ? $clog2(WARP_CNT) : 1;

    logic                valid;
    logic                ready;
    logic [WID_W-1:0]    wid;
    logic [RD_BITS-1:0]  rd;
    logic [XLEN-1:0]     data;
    logic [XLEN-1:0]     pc;

    modport src (output valid, wid, rd, data, pc, input ready);
    modport sink (input valid, wid, rd, data, pc, output ready);
    modport monitor (input valid, ready, wid, rd, data, pc);
endinterface

// single-cycle pulse, no back-pressure
interface branch_if import exec_types_pkg::*; #(
    parameter int WARP_CNT = 4
) ();
    localparam int WID_W = (WARP_CNT > 1) ? $clog2(WARP_CNT) : 1;

    logic             valid;
    logic             taken;
    logic [WID_W-1:0] wid;
    logic [XLEN-1:0]  dest;

    modport src (output valid, taken, wid, dest);
    modport sink (input valid, taken, wid, dest);
endinterface

interface warp_ctl_if import exec_types_pkg::*; import warp_ctl_pkg::*; #(
    parameter int WARP_CNT   = 4,
    parameter int THREAD_CNT = 4
) ();
    logic                  valid;
    sfu_op_e               op;
    logic [WARP_CNT-1:0]   wmask;
    logic [XLEN-1:0]       pc;
    logic [THREAD_CNT-1:0] tmask;

    modport src (output valid, op, wmask, pc, tmask);
    modport sink (input valid, op, wmask, pc, tmask);
endinterface

//--- verilog/warp_ctl_pkg.sv
// warp control opcodes and wspawn capture states; sfu opcodes fill the 4-bit dispatch op field
package warp_ctl_pkg;

    typedef enum logic [3:0] {
        // warp mask from rs1, start pc from rs2
        WSPAWN = 4'd0,
        // thread mask from rs1
        TMC    = 4'd1,
        // returns the issuing warp id
        WID    = 4'd2
    } sfu_op_e;

    // capture sequence after a wspawn at pc 0 with an empty mask
    typedef enum logic [1:0] {
        IDLE  = 2'd0,
        WAIT1 = 2'd1,
        WAIT2 = 2'd2,
        ARMED = 2'd3
    } wspawn_state_e;

endpackage

//--- verilog/exec_types_pkg.sv
// shared widths and ALU opcodes; op values above ECALL are not defined and complete with result 0
package exec_types_pkg;

    // data and pc width
    localparam int XLEN = 32;
    // dispatch op field, shared by the ALU and SFU opcode sets
    localparam int OP_BITS = 4;
    // destination register index
    localparam int RD_BITS = 5;

    typedef enum logic [OP_BITS-1:0] {
        ADD    = 4'd0,
        SUB    = 4'd1,
        AND    = 4'd2,
        OR     = 4'd3,
        XOR    = 4'd4,
        // signed less-than, result 0 or 1
        SLT    = 4'd5,
        BEQ    = 4'd6,
        BNE    = 4'd7,
        JAL    = 4'd8,
        JALR   = 4'd9,
        EBREAK = 4'd10,
        ECALL  = 4'd11
    } alu_op_e;

endpackage
